// ==== sources.f ====
src/isaPkg.sv
src/pipePkg.sv
src/fetchStage.sv
src/decodeStage.sv
src/executeStage.sv
src/memoryStage.sv
src/hazardUnit.sv
src/rv32iCore.sv
verif/coreTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f sources.f --top-module coreTb -o coreTb
output=$(./obj_dir/coreTb)
echo "$output"
if echo "$output" | grep -q "All tests passed"; then
    exit 0
fi
exit 1

// ==== verif/coreTb.sv ====
`default_nettype none

module coreTb
    import isaPkg::*;
;

    localparam wordT flagAddr  = 32'd1020;
    localparam int   pollLimit = 2000;

    // ALU tests, in order ADD SUB AND OR XOR SLT SLTU SLL SRL SRA
    localparam logic [6:0] aluF7 [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00,
                                          7'h00, 7'h00, 7'h00, 7'h00, 7'h20};
    localparam logic [2:0] aluF3 [10] = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4,
                                          3'd2, 3'd3, 3'd1, 3'd5, 3'd5};

    // Branch cases, each type once taken and once not taken
    localparam logic [2:0] brF3 [12] = '{3'd0, 3'd0, 3'd1, 3'd1, 3'd4, 3'd4,
                                         3'd5, 3'd5, 3'd6, 3'd6, 3'd7, 3'd7};
    localparam int   brRs1 [12] = '{1, 1, 1, 1, 3, 1, 1, 3, 1, 3, 3, 1};
    localparam int   brRs2 [12] = '{2, 4, 4, 2, 1, 3, 3, 1, 3, 1, 1, 3};
    localparam wordT brVal [5]  = '{32'd0, 32'd5, 32'd5, 32'hFFFF_FFFD, 32'd7};

    logic cpuClk = 1'b0;
    logic rstN;
    wordT instDbgAddr;
    wordT instDbgWrData;
    logic instDbgWrEn;
    wordT instDbgRdData;
    wordT dataDbgAddr;
    wordT dataDbgWrData;
    logic dataDbgWrEn;
    wordT dataDbgRdData;

    wordT prog [$];
    wordT lcgState   = 32'd96;
    int   errorCount = 0;
    int   checkCount = 0;

    always #2 cpuClk = ~cpuClk;

    rv32iCore dut0 (
        .cpuClk        (cpuClk),
        .rstN          (rstN),
        .instDbgAddr   (instDbgAddr),
        .instDbgWrData (instDbgWrData),
        .instDbgWrEn   (instDbgWrEn),
        .instDbgRdData (instDbgRdData),
        .dataDbgAddr   (dataDbgAddr),
        .dataDbgWrData (dataDbgWrData),
        .dataDbgWrEn   (dataDbgWrEn),
        .dataDbgRdData (dataDbgRdData)
    );

    // ----------------------------------------
    // Instruction assembly
    // ----------------------------------------
    function automatic wordT rType(logic [6:0] f7, logic [2:0] f3, regAddrT rd,
                                   regAddrT rs1, regAddrT rs2);
        return {f7, rs2, rs1, f3, rd, opcodeOp};
    endfunction

    function automatic wordT addi(regAddrT rd, regAddrT rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opcodeOpImm};
    endfunction

    function automatic wordT lw(regAddrT rd, regAddrT rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, opcodeLoad};
    endfunction

    function automatic wordT sw(regAddrT rs2, regAddrT rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opcodeStore};
    endfunction

    function automatic wordT bType(logic [2:0] f3, regAddrT rs1, regAddrT rs2,
                                   logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], opcodeBranch};
    endfunction

    function automatic wordT jal(regAddrT rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, opcodeJal};
    endfunction

    function automatic wordT lui(regAddrT rd, logic [19:0] imm);
        return {imm, rd, opcodeLui};
    endfunction

    // Upper part rounded so the sign extended low part adds back exactly
    function automatic void loadConst(regAddrT rd, wordT value);
        wordT upper;
        upper = value + 32'h800;
        prog.push_back(lui(rd, upper[31:12]));
        prog.push_back(addi(rd, rd, value[11:0]));
    endfunction

    // Done flag to word 255, then spin
    function automatic void finishProgram();
        prog.push_back(addi(5'd31, 5'd0, 12'd1));
        prog.push_back(sw(5'd31, 5'd0, flagAddr[11:0]));
        prog.push_back(jal(5'd0, 21'd0));
    endfunction

    function automatic wordT nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic branchRule(logic [2:0] f3, wordT a, wordT b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // ----------------------------------------
    // Compare tasks
    // ----------------------------------------
    task automatic checkData(input string name, input wordT expected, input wordT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic checkInst(input string name, input instrT expected, input instrT actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Read data shows one cycle after the address
    task automatic readData(input wordT addr, output wordT value);
        @(posedge cpuClk);
        dataDbgAddr <= addr;
        @(posedge cpuClk);
        @(negedge cpuClk);
        value = dataDbgRdData;
    endtask

    task automatic readInst(input wordT addr, output wordT value);
        @(posedge cpuClk);
        instDbgAddr <= addr;
        @(posedge cpuClk);
        @(negedge cpuClk);
        value = instDbgRdData;
    endtask

    // Load under reset, clear the flag, release and poll the flag
    task automatic runProgram(input string name);
        int waitCount;
        @(posedge cpuClk);
        rstN <= 1'b0;
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge cpuClk);
            instDbgWrEn   <= 1'b1;
            instDbgAddr   <= i * 4;
            instDbgWrData <= prog[i];
        end
        @(posedge cpuClk);
        instDbgWrEn   <= 1'b0;
        dataDbgWrEn   <= 1'b1;
        dataDbgAddr   <= flagAddr;
        dataDbgWrData <= '0;
        @(posedge cpuClk);
        dataDbgWrEn <= 1'b0;
        repeat (10) @(posedge cpuClk);
        rstN <= 1'b1;
        waitCount = 0;
        while (dataDbgRdData !== 32'd1 && waitCount < pollLimit) begin
            @(negedge cpuClk);
            waitCount++;
        end
        if (waitCount >= pollLimit) begin
            errorCount++;
            $display("Timeout: program %s never stored its done flag", name);
        end
    endtask

    // ----------------------------------------
    // Directed tests
    // ----------------------------------------
    task automatic testAlu();
        wordT        a;
        wordT        b;
        logic [11:0] immVal;
        wordT        expected [22];
        wordT        actual;
        prog.delete();
        for (int k = 0; k < 2; k++) begin
            a      = nextRandom();
            b      = nextRandom();
            immVal = 12'(nextRandom());
            expected[k * 11 + 0]  = a + b;
            expected[k * 11 + 1]  = a - b;
            expected[k * 11 + 2]  = a & b;
            expected[k * 11 + 3]  = a | b;
            expected[k * 11 + 4]  = a ^ b;
            expected[k * 11 + 5]  = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            expected[k * 11 + 6]  = (a < b) ? 32'd1 : 32'd0;
            expected[k * 11 + 7]  = a << b[4:0];
            expected[k * 11 + 8]  = a >> b[4:0];
            expected[k * 11 + 9]  = $signed(a) >>> b[4:0];
            expected[k * 11 + 10] = a + {{20{immVal[11]}}, immVal};
            loadConst(5'd1, a);
            loadConst(5'd2, b);
            for (int j = 0; j < 10; j++) begin
                prog.push_back(rType(aluF7[j], aluF3[j], 5'd3, 5'd1, 5'd2));
                prog.push_back(sw(5'd3, 5'd0, 12'((k * 11 + j) * 4)));
            end
            prog.push_back(addi(5'd3, 5'd1, immVal));
            prog.push_back(sw(5'd3, 5'd0, 12'((k * 11 + 10) * 4)));
        end
        finishProgram();
        runProgram("alu");
        for (int i = 0; i < 22; i++) begin
            readData(i * 4, actual);
            checkData($sformatf("alu result %0d", i), expected[i], actual);
        end
    endtask

    // Chain with no spacing, each result used by the next two
    task automatic testForwarding();
        wordT c;
        wordT expected [5];
        wordT actual;
        c           = nextRandom();
        expected[0] = c + c;
        expected[1] = expected[0] + c;
        expected[2] = expected[1] + expected[0];
        expected[3] = expected[2] + expected[1];
        expected[4] = expected[3] + 32'd16;
        prog.delete();
        loadConst(5'd1, c);
        prog.push_back(rType(7'h00, 3'b000, 5'd2, 5'd1, 5'd1));
        prog.push_back(rType(7'h00, 3'b000, 5'd3, 5'd2, 5'd1));
        prog.push_back(rType(7'h00, 3'b000, 5'd4, 5'd3, 5'd2));
        prog.push_back(rType(7'h00, 3'b000, 5'd5, 5'd4, 5'd3));
        prog.push_back(addi(5'd6, 5'd5, 12'd7));
        prog.push_back(addi(5'd6, 5'd6, 12'd9));
        for (int i = 0; i < 5; i++) begin
            prog.push_back(sw(5'(i + 2), 5'd0, 12'(128 + i * 4)));
        end
        finishProgram();
        runProgram("forwarding");
        for (int i = 0; i < 5; i++) begin
            readData(128 + i * 4, actual);
            checkData($sformatf("forwarding sum %0d", i), expected[i], actual);
        end
    endtask

    task automatic testLoadUse();
        wordT v;
        wordT actual;
        v = nextRandom();
        prog.delete();
        loadConst(5'd1, v);
        prog.push_back(sw(5'd1, 5'd0, 12'd160));
        prog.push_back(lw(5'd2, 5'd0, 12'd160));
        prog.push_back(addi(5'd3, 5'd2, 12'd25));
        prog.push_back(sw(5'd3, 5'd0, 12'd164));
        // Loaded value used as the second source
        prog.push_back(lw(5'd4, 5'd0, 12'd160));
        prog.push_back(rType(7'h00, 3'b000, 5'd5, 5'd3, 5'd4));
        prog.push_back(sw(5'd5, 5'd0, 12'd168));
        finishProgram();
        runProgram("load use");
        readData(32'd160, actual);
        checkData("load use stored", v, actual);
        readData(32'd164, actual);
        checkData("load use addi", v + 32'd25, actual);
        readData(32'd168, actual);
        checkData("load use add", v + 32'd25 + v, actual);
    endtask

    // Skipped path sets x20 and x21, the target sums them plus 16
    task automatic testBranches();
        wordT expected [12];
        wordT linkPc;
        wordT actual;
        prog.delete();
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(addi(5'd2, 5'd0, 12'd5));
        prog.push_back(addi(5'd3, 5'd0, 12'hFFD));
        prog.push_back(addi(5'd4, 5'd0, 12'd7));
        for (int i = 0; i < 12; i++) begin
            expected[i] = branchRule(brF3[i], brVal[brRs1[i]], brVal[brRs2[i]]) ?
                          32'd16 : 32'd19;
            prog.push_back(addi(5'd20, 5'd0, 12'd0));
            prog.push_back(addi(5'd21, 5'd0, 12'd0));
            prog.push_back(addi(5'd22, 5'd0, 12'd0));
            prog.push_back(bType(brF3[i], 5'(brRs1[i]), 5'(brRs2[i]), 13'd12));
            prog.push_back(addi(5'd20, 5'd0, 12'd1));
            prog.push_back(addi(5'd21, 5'd0, 12'd2));
            prog.push_back(rType(7'h00, 3'b000, 5'd22, 5'd20, 5'd21));
            prog.push_back(addi(5'd22, 5'd22, 12'd16));
            prog.push_back(sw(5'd22, 5'd0, 12'(256 + i * 4)));
        end
        prog.push_back(addi(5'd20, 5'd0, 12'd0));
        prog.push_back(addi(5'd21, 5'd0, 12'd0));
        linkPc = prog.size() * 4 + 4;
        prog.push_back(jal(5'd5, 21'd12));
        prog.push_back(addi(5'd20, 5'd0, 12'd1));
        prog.push_back(addi(5'd21, 5'd0, 12'd2));
        prog.push_back(rType(7'h00, 3'b000, 5'd22, 5'd20, 5'd21));
        prog.push_back(sw(5'd5, 5'd0, 12'd320));
        prog.push_back(sw(5'd22, 5'd0, 12'd324));
        finishProgram();
        runProgram("branches");
        for (int i = 0; i < 12; i++) begin
            readData(256 + i * 4, actual);
            checkData($sformatf("branch case %0d", i), expected[i], actual);
        end
        readData(32'd320, actual);
        checkData("jal link", linkPc, actual);
        readData(32'd324, actual);
        checkData("jal skipped path", 32'd0, actual);
    endtask

    task automatic testDebugPorts();
        instrT instVal;
        wordT  dataVal;
        wordT  actual;
        instVal = addi(5'd7, 5'd8, 12'(nextRandom()));
        dataVal = nextRandom();
        @(posedge cpuClk);
        instDbgWrEn   <= 1'b1;
        instDbgAddr   <= 32'd1008;
        instDbgWrData <= instVal;
        dataDbgWrEn   <= 1'b1;
        dataDbgAddr   <= 32'd800;
        dataDbgWrData <= dataVal;
        @(posedge cpuClk);
        instDbgWrEn <= 1'b0;
        dataDbgWrEn <= 1'b0;
        readInst(32'd1008, actual);
        checkInst("debug instruction word", instVal, actual);
        readData(32'd800, actual);
        checkData("debug data word", dataVal, actual);
    endtask

    initial begin
        rstN          <= 1'b0;
        instDbgAddr   <= '0;
        instDbgWrData <= '0;
        instDbgWrEn   <= 1'b0;
        dataDbgAddr   <= '0;
        dataDbgWrData <= '0;
        dataDbgWrEn   <= 1'b0;
        testAlu();
        testForwarding();
        testLoadUse();
        testBranches();
        testDebugPorts();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/rv32iCore.sv ====
`default_nettype none

module rv32iCore
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic cpuClk,
    input  logic rstN,
    input  wordT instDbgAddr,
    input  wordT instDbgWrData,
    input  logic instDbgWrEn,
    output wordT instDbgRdData,
    input  wordT dataDbgAddr,
    input  wordT dataDbgWrData,
    input  logic dataDbgWrEn,
    output wordT dataDbgRdData
);

    ifIdT    ifId;
    idExT    idEx;
    exMemT   exMem;
    memWbT   memWb;
    logic    stall;
    logic    flush;
    logic    redirect;
    wordT    redirectPc;
    regAddrT rs1;
    regAddrT rs2;
    fwdSelT  fwdA;
    fwdSelT  fwdB;

    // ----------------------------------------
    // Pipeline stages
    // ----------------------------------------
    fetchStage fetch0 (
        .cpuClk        (cpuClk),
        .rstN          (rstN),
        .stall         (stall),
        .flush         (flush),
        .redirect      (redirect),
        .redirectPc    (redirectPc),
        .instDbgAddr   (instDbgAddr),
        .instDbgWrData (instDbgWrData),
        .instDbgWrEn   (instDbgWrEn),
        .instDbgRdData (instDbgRdData),
        .ifId          (ifId)
    );

    decodeStage decode0 (
        .cpuClk (cpuClk),
        .rstN   (rstN),
        .stall  (stall),
        .flush  (flush),
        .ifId   (ifId),
        .memWb  (memWb),
        .idEx   (idEx),
        .rs1    (rs1),
        .rs2    (rs2)
    );

    executeStage execute0 (
        .cpuClk     (cpuClk),
        .rstN       (rstN),
        .idEx       (idEx),
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .memWb      (memWb),
        .exMem      (exMem),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    memoryStage memory0 (
        .cpuClk        (cpuClk),
        .rstN          (rstN),
        .exMem         (exMem),
        .dataDbgAddr   (dataDbgAddr),
        .dataDbgWrData (dataDbgWrData),
        .dataDbgWrEn   (dataDbgWrEn),
        .memWb         (memWb),
        .dataDbgRdData (dataDbgRdData)
    );

    // Stall, flush and forwarding control
    hazardUnit hazard0 (
        .rs1      (rs1),
        .rs2      (rs2),
        .idEx     (idEx),
        .exMem    (exMem),
        .memWb    (memWb),
        .redirect (redirect),
        .stall    (stall),
        .flush    (flush),
        .fwdA     (fwdA),
        .fwdB     (fwdB)
    );

endmodule

`default_nettype wire

// ==== src/hazardUnit.sv ====
`default_nettype none

module hazardUnit
    import isaPkg::*;
    import pipePkg::*;
(
    input  regAddrT rs1,
    input  regAddrT rs2,
    input  idExT    idEx,
    input  exMemT   exMem,
    input  memWbT   memWb,
    input  logic    redirect,
    output logic    stall,
    output logic    flush,
    output fwdSelT  fwdA,
    output fwdSelT  fwdB
);

    // Nearest producer first
    function automatic fwdSelT pickSource(regAddrT src, exMemT mem, memWbT wb);
        if (src == '0) begin
            return REGFILE;
        end
        if (mem.regWrite && mem.rd == src) begin
            return FROMMEM;
        end
        if (wb.regWrite && wb.rd == src) begin
            return FROMWB;
        end
        return REGFILE;
    endfunction

    // Load in EX feeding the instruction in ID
    assign stall = idEx.valid && idEx.memRead && idEx.rd != '0 &&
                   (idEx.rd == rs1 || idEx.rd == rs2);

    assign flush = redirect;

    assign fwdA = pickSource(idEx.rs1, exMem, memWb);
    assign fwdB = pickSource(idEx.rs2, exMem, memWb);

endmodule

`default_nettype wire

// ==== src/memoryStage.sv ====
`default_nettype none

module memoryStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic  cpuClk,
    input  logic  rstN,
    input  exMemT exMem,
    input  wordT  dataDbgAddr,
    input  wordT  dataDbgWrData,
    input  logic  dataDbgWrEn,
    output memWbT memWb,
    output wordT  dataDbgRdData
);

    wordT                   dataMem [memDepth];
    logic [memAddrBits-1:0] cpuIdx;
    logic [memAddrBits-1:0] dbgIdx;
    wordT                   loadWord;
    wordT                   aluQ;
    logic                   isLoadQ;
    regAddrT                rdQ;
    logic                   regWriteQ;

    assign cpuIdx = exMem.aluResult[memAddrBits+1:2];
    assign dbgIdx = dataDbgAddr[memAddrBits+1:2];

    // Dual port data memory, core on one side and debug on the other
    always_ff @(posedge cpuClk) begin
        if (exMem.memWrite) begin
            dataMem[cpuIdx] <= exMem.storeData;
        end
        if (dataDbgWrEn) begin
            dataMem[dbgIdx] <= dataDbgWrData;
        end
        loadWord      <= dataMem[cpuIdx];
        dataDbgRdData <= dataMem[dbgIdx];
    end

    // ----------------------------------------
    // MEM/WB register
    // ----------------------------------------
    always_ff @(posedge cpuClk) begin
        aluQ <= exMem.aluResult;
        rdQ  <= exMem.rd;
        if (!rstN) begin
            isLoadQ   <= 1'b0;
            regWriteQ <= 1'b0;
        end else begin
            isLoadQ   <= exMem.memRead;
            regWriteQ <= exMem.regWrite;
        end
    end

    // Load data arrives with the register, so the select sits after it
    assign memWb.wbData   = isLoadQ ? loadWord : aluQ;
    assign memWb.rd       = rdQ;
    assign memWb.regWrite = regWriteQ;

endmodule

`default_nettype wire

// ==== src/executeStage.sv ====
`default_nettype none

module executeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic   cpuClk,
    input  logic   rstN,
    input  idExT   idEx,
    input  fwdSelT fwdA,
    input  fwdSelT fwdB,
    input  memWbT  memWb,
    output exMemT  exMem,
    output logic   redirect,
    output wordT   redirectPc
);

    wordT fwdValA;
    wordT fwdValB;
    wordT opA;
    wordT opB;
    wordT aluOut;
    logic taken;

    function automatic wordT pickOperand(fwdSelT sel, wordT regVal, wordT memVal,
                                         wordT wbVal);
        case (sel)
            FROMMEM: return memVal;
            FROMWB:  return wbVal;
            default: return regVal;
        endcase
    endfunction

    // ----------------------------------------
    // Operand selection
    // ----------------------------------------
    assign fwdValA = pickOperand(fwdA, idEx.rs1Val, exMem.aluResult, memWb.wbData);
    assign fwdValB = pickOperand(fwdB, idEx.rs2Val, exMem.aluResult, memWb.wbData);
    assign opA     = idEx.usePcA ? idEx.pc : fwdValA;
    assign opB     = idEx.useImmB ? idEx.imm : fwdValB;

    always_comb begin
        case (idEx.aluOp)
            SUB:     aluOut = opA - opB;
            SLL:     aluOut = opA << opB[4:0];
            SLT:     aluOut = {31'b0, $signed(opA) < $signed(opB)};
            SLTU:    aluOut = {31'b0, opA < opB};
            XOR:     aluOut = opA ^ opB;
            SRL:     aluOut = opA >> opB[4:0];
            SRA:     aluOut = $signed(opA) >>> opB[4:0];
            OR:      aluOut = opA | opB;
            AND:     aluOut = opA & opB;
            COPYB:   aluOut = opB;
            default: aluOut = opA + opB;
        endcase
    end

    // Compare on the forwarded register values, not on the ALU inputs
    always_comb begin
        case (idEx.branch)
            BEQ:     taken = fwdValA == fwdValB;
            BNE:     taken = fwdValA != fwdValB;
            BLT:     taken = $signed(fwdValA) < $signed(fwdValB);
            BGE:     taken = $signed(fwdValA) >= $signed(fwdValB);
            BLTU:    taken = fwdValA < fwdValB;
            BGEU:    taken = fwdValA >= fwdValB;
            default: taken = 1'b0;
        endcase
    end

    assign redirect   = idEx.valid && (idEx.isJal || taken);
    assign redirectPc = aluOut;

    // EX/MEM register, JAL carries its link address as the result
    always_ff @(posedge cpuClk) begin
        exMem.aluResult <= idEx.isJal ? idEx.pc + pcStep : aluOut;
        exMem.storeData <= fwdValB;
        exMem.rd        <= idEx.rd;
        if (!rstN) begin
            exMem.memRead  <= 1'b0;
            exMem.memWrite <= 1'b0;
            exMem.regWrite <= 1'b0;
        end else begin
            exMem.memRead  <= idEx.valid && idEx.memRead;
            exMem.memWrite <= idEx.valid && idEx.memWrite;
            exMem.regWrite <= idEx.valid && idEx.regWrite;
        end
    end

endmodule

`default_nettype wire

// ==== src/decodeStage.sv ====
`default_nettype none

module decodeStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic    cpuClk,
    input  logic    rstN,
    input  logic    stall,
    input  logic    flush,
    input  ifIdT    ifId,
    input  memWbT   memWb,
    output idExT    idEx,
    output regAddrT rs1,
    output regAddrT rs2
);

    wordT   regFile [1:31];
    instrT  instr;
    wordT   immI;
    wordT   immS;
    wordT   immB;
    wordT   immU;
    wordT   immJ;
    wordT   imm;
    aluOpT  aluOp;
    branchT branch;
    logic   isJal;
    logic   useImmB;
    logic   usePcA;
    logic   memRead;
    logic   memWrite;
    logic   regWrite;
    logic   useRs1;
    logic   useRs2;
    wordT   rs1Val;
    wordT   rs2Val;

    function automatic aluOpT aluFromFunct(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? SUB : ADD;
            3'b001:  return SLL;
            3'b010:  return SLT;
            3'b011:  return SLTU;
            3'b100:  return XOR;
            3'b101:  return alt ? SRA : SRL;
            3'b110:  return OR;
            default: return AND;
        endcase
    endfunction

    function automatic branchT branchFromFunct(logic [2:0] funct3);
        case (funct3)
            3'b000:  return BEQ;
            3'b001:  return BNE;
            3'b100:  return BLT;
            3'b101:  return BGE;
            3'b110:  return BLTU;
            3'b111:  return BGEU;
            default: return NONE;
        endcase
    endfunction

    assign instr = ifId.instr;

    // ----------------------------------------
    // Immediates, one per format view
    // ----------------------------------------
    assign immI = {{20{instr.iForm.imm[11]}}, instr.iForm.imm};
    assign immS = {{20{instr.sForm.immHi[6]}}, instr.sForm.immHi, instr.sForm.immLo};
    assign immB = {{20{instr.bForm.imm12}}, instr.bForm.imm11, instr.bForm.immHi,
                   instr.bForm.immLo, 1'b0};
    assign immU = {instr.uForm.imm, 12'b0};
    assign immJ = {{12{instr.jForm.imm20}}, instr.jForm.immHi, instr.jForm.imm11,
                   instr.jForm.immLo, 1'b0};

    // Branches and JAL let the ALU form the target as pc + imm
    always_comb begin
        aluOp    = ADD;
        branch   = NONE;
        imm      = '0;
        isJal    = 1'b0;
        useImmB  = 1'b0;
        usePcA   = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        regWrite = 1'b0;
        useRs1   = 1'b0;
        useRs2   = 1'b0;
        case (instr.rForm.opcode)
            opcodeOp: begin
                aluOp    = aluFromFunct(instr.rForm.funct3, instr.rForm.funct7[5]);
                regWrite = 1'b1;
                useRs1   = 1'b1;
                useRs2   = 1'b1;
            end
            opcodeOpImm: begin
                // Bit 30 selects SRA only, for ADDI it is immediate data
                aluOp    = aluFromFunct(instr.rForm.funct3,
                                        instr.rForm.funct3 == 3'b101 && instr.rForm.funct7[5]);
                imm      = immI;
                useImmB  = 1'b1;
                regWrite = 1'b1;
                useRs1   = 1'b1;
            end
            opcodeLoad: begin
                imm      = immI;
                useImmB  = 1'b1;
                memRead  = 1'b1;
                regWrite = 1'b1;
                useRs1   = 1'b1;
            end
            opcodeStore: begin
                imm      = immS;
                useImmB  = 1'b1;
                memWrite = 1'b1;
                useRs1   = 1'b1;
                useRs2   = 1'b1;
            end
            opcodeBranch: begin
                branch  = branchFromFunct(instr.bForm.funct3);
                imm     = immB;
                useImmB = 1'b1;
                usePcA  = 1'b1;
                useRs1  = 1'b1;
                useRs2  = 1'b1;
            end
            opcodeJal: begin
                imm      = immJ;
                isJal    = 1'b1;
                useImmB  = 1'b1;
                usePcA   = 1'b1;
                regWrite = 1'b1;
            end
            opcodeLui: begin
                aluOp    = COPYB;
                imm      = immU;
                useImmB  = 1'b1;
                regWrite = 1'b1;
            end
            opcodeAuipc: begin
                imm      = immU;
                useImmB  = 1'b1;
                usePcA   = 1'b1;
                regWrite = 1'b1;
            end
            default: ;
        endcase
    end

    // Unused source fields read as x0 so they never stall or forward
    assign rs1 = useRs1 ? instr.rForm.rs1 : '0;
    assign rs2 = useRs2 ? instr.rForm.rs2 : '0;

    // ----------------------------------------
    // Register file, write first
    // ----------------------------------------
    always_ff @(posedge cpuClk) begin
        if (memWb.regWrite && memWb.rd != '0) begin
            regFile[memWb.rd] <= memWb.wbData;
        end
    end

    assign rs1Val = (rs1 == '0) ? '0 :
                    (memWb.regWrite && memWb.rd == rs1) ? memWb.wbData : regFile[rs1];
    assign rs2Val = (rs2 == '0) ? '0 :
                    (memWb.regWrite && memWb.rd == rs2) ? memWb.wbData : regFile[rs2];

    // ID/EX register, a bubble is all zero
    always_ff @(posedge cpuClk) begin
        if (!rstN || stall || flush) begin
            idEx <= '0;
        end else begin
            idEx.pc       <= ifId.pc;
            idEx.rs1Val   <= rs1Val;
            idEx.rs2Val   <= rs2Val;
            idEx.imm      <= imm;
            idEx.rs1      <= rs1;
            idEx.rs2      <= rs2;
            idEx.rd       <= instr.rForm.rd;
            idEx.aluOp    <= aluOp;
            idEx.branch   <= branch;
            idEx.isJal    <= isJal;
            idEx.useImmB  <= useImmB;
            idEx.usePcA   <= usePcA;
            idEx.memRead  <= memRead;
            idEx.memWrite <= memWrite;
            idEx.regWrite <= regWrite;
            idEx.valid    <= ifId.valid;
        end
    end

endmodule

`default_nettype wire

// ==== src/fetchStage.sv ====
`default_nettype none

module fetchStage
    import isaPkg::*;
    import pipePkg::*;
(
    input  logic cpuClk,
    input  logic rstN,
    input  logic stall,
    input  logic flush,
    input  logic redirect,
    input  wordT redirectPc,
    input  wordT instDbgAddr,
    input  wordT instDbgWrData,
    input  logic instDbgWrEn,
    output wordT instDbgRdData,
    output ifIdT ifId
);

    wordT                   instMem [memDepth];
    wordT                   pc;
    logic [memAddrBits-1:0] fetchIdx;
    logic [memAddrBits-1:0] dbgIdx;

    assign fetchIdx = pc[memAddrBits+1:2];
    assign dbgIdx   = instDbgAddr[memAddrBits+1:2];

    // Debug port, used to load programs while the core sits in reset
    always_ff @(posedge cpuClk) begin
        if (instDbgWrEn) begin
            instMem[dbgIdx] <= instDbgWrData;
        end
        instDbgRdData <= instMem[dbgIdx];
    end

    // Next PC, a redirect from EX wins over everything
    always_ff @(posedge cpuClk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (redirect) begin
            pc <= redirectPc;
        end else if (!stall) begin
            pc <= pc + pcStep;
        end
    end

    // IF/ID register with synchronous instruction read
    always_ff @(posedge cpuClk) begin
        if (!rstN || flush) begin
            ifId.pc    <= '0;
            ifId.instr <= nopInstr;
            ifId.valid <= 1'b0;
        end else if (!stall) begin
            ifId.pc    <= pc;
            ifId.instr <= instMem[fetchIdx];
            ifId.valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/pipePkg.sv ====
`default_nettype none

package pipePkg;

    import isaPkg::*;

    // Both memories are word addressed internally
    localparam int   memDepth    = 256;
    localparam int   memAddrBits = 8;
    localparam wordT pcStep      = 32'd4;

    // ----------------------------------------
    // Stage registers
    // ----------------------------------------
    typedef struct packed {
        wordT  pc;
        instrT instr;
        logic  valid;
    } ifIdT;

    typedef struct packed {
        wordT    pc;
        wordT    rs1Val;
        wordT    rs2Val;
        wordT    imm;
        regAddrT rs1;
        regAddrT rs2;
        regAddrT rd;
        aluOpT   aluOp;
        branchT  branch;
        logic    isJal;
        logic    useImmB;
        logic    usePcA;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
        logic    valid;
    } idExT;

    typedef struct packed {
        wordT    aluResult;
        wordT    storeData;
        regAddrT rd;
        logic    memRead;
        logic    memWrite;
        logic    regWrite;
    } exMemT;

    typedef struct packed {
        wordT    wbData;
        regAddrT rd;
        logic    regWrite;
    } memWbT;

    typedef enum logic [1:0] {
        REGFILE, FROMMEM, FROMWB
    } fwdSelT;

endpackage

`default_nettype wire

// ==== src/isaPkg.sv ====
`default_nettype none

package isaPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;

    // ----------------------------------------
    // Instruction formats
    // ----------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        regAddrT    rd;
        logic [6:0] opcode;
    } rFormT;

    typedef struct packed {
        logic [11:0] imm;
        regAddrT     rs1;
        logic [2:0]  funct3;
        regAddrT     rd;
        logic [6:0]  opcode;
    } iFormT;

    typedef struct packed {
        logic [6:0] immHi;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFormT;

    // Branch offset bits are scattered, bit 0 is implied
    typedef struct packed {
        logic       imm12;
        logic [5:0] immHi;
        regAddrT    rs2;
        regAddrT    rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;
        logic       imm11;
        logic [6:0] opcode;
    } bFormT;

    typedef struct packed {
        logic [19:0] imm;
        regAddrT     rd;
        logic [6:0]  opcode;
    } uFormT;

    typedef struct packed {
        logic        imm20;
        logic [9:0]  immLo;
        logic        imm11;
        logic [7:0]  immHi;
        regAddrT     rd;
        logic [6:0]  opcode;
    } jFormT;

    typedef union packed {
        rFormT rForm;
        iFormT iForm;
        sFormT sForm;
        bFormT bForm;
        uFormT uForm;
        jFormT jForm;
    } instrT;

    // ----------------------------------------
    // Operation codes
    // ----------------------------------------
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, COPYB
    } aluOpT;

    typedef enum logic [2:0] {
        NONE, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } branchT;

    localparam logic [6:0] opcodeOp     = 7'b0110011;
    localparam logic [6:0] opcodeOpImm  = 7'b0010011;
    localparam logic [6:0] opcodeLoad   = 7'b0000011;
    localparam logic [6:0] opcodeStore  = 7'b0100011;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeJal    = 7'b1101111;
    localparam logic [6:0] opcodeLui    = 7'b0110111;
    localparam logic [6:0] opcodeAuipc  = 7'b0010111;

    // addi x0, x0, 0
    localparam wordT nopInstr = 32'h0000_0013;

endpackage

`default_nettype wire
